//--- ps2Pkg.sv
`default_nettype none

package ps2Pkg;

	typedef enum logic [3:0]
	{
		idle,
		waitHighData,
		dataBit,
		waitHighParity,
		parityBit,
		waitHighStop,
		stopBit,
		finish,
		drainLow
	} frameState_e;

	typedef enum logic [1:0]
	{
		codeByte,
		extPrefix,
		breakPrefix
	} byteKind_e;

	typedef struct packed
	{
		logic [7:0] code;
		logic       pressed;	// make when set.
		logic       extended;	// code came after E0.
	} keyEvent_t;

	typedef struct packed
	{
		logic shift;
		logic ctrl;
		logic alt;
	} modifiers_t;

	localparam logic [7:0] EXT_PREFIX   = 8'hE0;
	localparam logic [7:0] BREAK_PREFIX = 8'hF0;

	localparam int              TIMER_W       = 11;
	localparam logic [TIMER_W-1:0] FRAME_TIMEOUT = 11'd2045;	// cycles from frame start.

	localparam logic [7:0] LSHIFT_CODE = 8'h12;
	localparam logic [7:0] RSHIFT_CODE = 8'h59;
	localparam logic [7:0] CTRL_CODE   = 8'h14;
	localparam logic [7:0] ALT_CODE    = 8'h11;

	localparam int HELD_COUNT_W  = 9;
	localparam int KEY_INDEX_W   = 9;	// extended bit plus code.
	localparam int HELD_MAP_SIZE = 1 << KEY_INDEX_W;

endpackage

`default_nettype wire

//--- ps2FrameRx.sv
`timescale 1ns/100ps
`default_nettype none

module ps2FrameRx
(
	input  wire logic       CLK,
	input  wire logic       RESET_X,
	input  wire logic       ps2Clk,
	input  wire logic       ps2Data,
	output logic      [7:0] rxByte,
	output logic            byteValid,
	output logic            frameError
);

	logic clkMeta;
	logic clkSync;
	logic dataMeta;
	logic dataSync;

	ps2Pkg::frameState_e state;
	logic [2:0] bitCount;
	logic [7:0] shiftReg;
	logic       parityOk;
	logic [ps2Pkg::TIMER_W-1:0] timer;
	logic       inFrame;
	logic       abort;

	// both lines idle high.
	always_ff @(posedge CLK or negedge RESET_X)
	begin
		if (!RESET_X)
		begin
			clkMeta  <= 1'b1;
			clkSync  <= 1'b1;
			dataMeta <= 1'b1;
			dataSync <= 1'b1;
		end
		else
		begin
			clkMeta  <= ps2Clk;
			clkSync  <= clkMeta;
			dataMeta <= ps2Data;
			dataSync <= dataMeta;
		end
	end

	assign inFrame = (state != ps2Pkg::idle) && (state != ps2Pkg::finish) &&
		(state != ps2Pkg::drainLow);
	assign abort = inFrame && (timer == ps2Pkg::FRAME_TIMEOUT);

	// saturates at the limit until the receiver is back in idle.
	always_ff @(posedge CLK or negedge RESET_X)
	begin
		if (!RESET_X)
			timer <= '0;
		else if (state == ps2Pkg::idle)
			timer <= '0;
		else if (timer != ps2Pkg::FRAME_TIMEOUT)
			timer <= timer + 1'b1;
	end

	always_ff @(posedge CLK or negedge RESET_X)
	begin
		if (!RESET_X)
		begin
			state    <= ps2Pkg::idle;
			bitCount <= '0;
			parityOk <= 1'b0;
		end
		else if (abort)
			state <= ps2Pkg::drainLow;	// stalled frame.
		else
		begin
			case (state)
				ps2Pkg::idle:
				begin
					bitCount <= '0;
					if (!clkSync && !dataSync)
						state <= ps2Pkg::waitHighData;	// start bit.
				end
				ps2Pkg::waitHighData:
				begin
					if (clkSync)
						state <= ps2Pkg::dataBit;
				end
				ps2Pkg::dataBit:
				begin
					if (!clkSync)
					begin
						bitCount <= bitCount + 1'b1;
						if (bitCount == 3'd7)
							state <= ps2Pkg::waitHighParity;
						else
							state <= ps2Pkg::waitHighData;
					end
				end
				ps2Pkg::waitHighParity:
				begin
					if (clkSync)
						state <= ps2Pkg::parityBit;
				end
				ps2Pkg::parityBit:
				begin
					if (!clkSync)
					begin
						parityOk <= (dataSync == ~(^shiftReg));	// odd parity.
						state    <= ps2Pkg::waitHighStop;
					end
				end
				ps2Pkg::waitHighStop:
				begin
					if (clkSync)
						state <= ps2Pkg::stopBit;
				end
				ps2Pkg::stopBit:
				begin
					if (!clkSync)
						state <= ps2Pkg::finish;
				end
				ps2Pkg::finish:
					state <= ps2Pkg::drainLow;
				ps2Pkg::drainLow:
				begin
					if (clkSync)
						state <= ps2Pkg::idle;
				end
				default:
					state <= ps2Pkg::idle;
			endcase
		end
	end

	// lsb arrives first.
	always_ff @(posedge CLK)
	begin
		if ((state == ps2Pkg::dataBit) && !clkSync)
			shiftReg <= {dataSync, shiftReg[7:1]};
	end

	assign rxByte     = shiftReg;
	assign byteValid  = (state == ps2Pkg::finish) && parityOk;
	assign frameError = ((state == ps2Pkg::finish) && !parityOk) || abort;

	// a frame ends in one single-cycle outcome.
	singleOutcome: assert property (@(posedge CLK) disable iff (!RESET_X)
		(byteValid || frameError) |=> !(byteValid || frameError));

endmodule

`default_nettype wire

//--- ps2ScanDecode.sv
`timescale 1ns/100ps
`default_nettype none

module ps2ScanDecode
(
	input  wire logic              CLK,
	input  wire logic              RESET_X,
	input  wire logic        [7:0] rxByte,
	input  wire logic              byteValid,
	input  wire logic              frameError,
	output ps2Pkg::keyEvent_t      keyEvent,
	output logic                   eventValid
);

	ps2Pkg::byteKind_e kind;
	logic extPending;
	logic breakPending;

	always_comb
	begin
		if (rxByte == ps2Pkg::EXT_PREFIX)
			kind = ps2Pkg::extPrefix;
		else if (rxByte == ps2Pkg::BREAK_PREFIX)
			kind = ps2Pkg::breakPrefix;
		else
			kind = ps2Pkg::codeByte;	// E1 lands here too.
	end

	always_ff @(posedge CLK or negedge RESET_X)
	begin
		if (!RESET_X)
		begin
			extPending   <= 1'b0;
			breakPending <= 1'b0;
			eventValid   <= 1'b0;
		end
		else
		begin
			eventValid <= 1'b0;
			if (frameError)
			begin
				extPending   <= 1'b0;	// drop a half-built sequence.
				breakPending <= 1'b0;
			end
			else if (byteValid)
			begin
				case (kind)
					ps2Pkg::extPrefix:
						extPending <= 1'b1;
					ps2Pkg::breakPrefix:
						breakPending <= 1'b1;
					default:
					begin
						eventValid   <= 1'b1;
						extPending   <= 1'b0;
						breakPending <= 1'b0;
					end
				endcase
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (byteValid && !frameError && (kind == ps2Pkg::codeByte))
		begin
			keyEvent.code     <= rxByte;
			keyEvent.pressed  <= !breakPending;
			keyEvent.extended <= extPending;
		end
	end

	// bytes are a full ps2 frame apart.
	noBackToBack: assert property (@(posedge CLK) disable iff (!RESET_X)
		eventValid |=> !eventValid);

endmodule

`default_nettype wire

//--- ps2KeyState.sv
`timescale 1ns/100ps
`default_nettype none

module ps2KeyState
(
	input  wire logic                            CLK,
	input  wire logic                            RESET_X,
	input  wire ps2Pkg::keyEvent_t               keyEvent,
	input  wire logic                            eventValid,
	output ps2Pkg::keyEvent_t                    lastEvent,
	output logic                                 lastValid,
	output logic [ps2Pkg::HELD_COUNT_W-1:0]      heldCount,
	output ps2Pkg::modifiers_t                   mods
);

	logic [ps2Pkg::HELD_MAP_SIZE-1:0] heldMap;
	logic [ps2Pkg::KEY_INDEX_W-1:0]   keyIndex;
	logic heldBit;
	logic setKey;
	logic clearKey;

	assign keyIndex = {keyEvent.extended, keyEvent.code};
	assign heldBit  = heldMap[keyIndex];
	assign setKey   = eventValid && keyEvent.pressed && !heldBit;	// repeats ignored.
	assign clearKey = eventValid && !keyEvent.pressed && heldBit;

	always_ff @(posedge CLK or negedge RESET_X)
	begin
		if (!RESET_X)
		begin
			heldMap   <= '0;
			heldCount <= '0;
		end
		else if (setKey)
		begin
			heldMap[keyIndex] <= 1'b1;
			heldCount         <= heldCount + 1'b1;
		end
		else if (clearKey)
		begin
			heldMap[keyIndex] <= 1'b0;
			heldCount         <= heldCount - 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RESET_X)
	begin
		if (!RESET_X)
		begin
			lastEvent <= '0;
			lastValid <= 1'b0;
		end
		else
		begin
			lastValid <= eventValid;
			if (eventValid)
				lastEvent <= keyEvent;
		end
	end

	// levels follow the map, so they move with heldCount.
	assign mods.shift = heldMap[{1'b0, ps2Pkg::LSHIFT_CODE}] |
		heldMap[{1'b0, ps2Pkg::RSHIFT_CODE}];
	assign mods.ctrl = heldMap[{1'b0, ps2Pkg::CTRL_CODE}] |
		heldMap[{1'b1, ps2Pkg::CTRL_CODE}];
	assign mods.alt = heldMap[{1'b0, ps2Pkg::ALT_CODE}] |
		heldMap[{1'b1, ps2Pkg::ALT_CODE}];

	// a new key at full count would wrap past 511.
	heldNoWrap: assert property (@(posedge CLK) disable iff (!RESET_X)
		!(setKey && (heldCount == {ps2Pkg::HELD_COUNT_W{1'b1}})));

endmodule

`default_nettype wire

//--- ps2Keyboard.sv
`timescale 1ns/100ps
`default_nettype none

module ps2Keyboard
(
	input  wire logic                       CLK,
	input  wire logic                       RESET_X,
	input  wire logic                       ps2Clk,
	input  wire logic                       ps2Data,
	output ps2Pkg::keyEvent_t               lastEvent,
	output logic                            lastValid,
	output logic [ps2Pkg::HELD_COUNT_W-1:0] heldCount,
	output ps2Pkg::modifiers_t              mods,
	output logic                            frameError
);

	logic [7:0]        rxByte;
	logic              byteValid;
	ps2Pkg::keyEvent_t keyEvent;
	logic              eventValid;

	ps2FrameRx frameRx (
		.CLK        (CLK),
		.RESET_X    (RESET_X),
		.ps2Clk     (ps2Clk),
		.ps2Data    (ps2Data),
		.rxByte     (rxByte),
		.byteValid  (byteValid),
		.frameError (frameError)
	);

	ps2ScanDecode scanDecode (
		.CLK        (CLK),
		.RESET_X    (RESET_X),
		.rxByte     (rxByte),
		.byteValid  (byteValid),
		.frameError (frameError),
		.keyEvent   (keyEvent),
		.eventValid (eventValid)
	);

	ps2KeyState keyState (
		.CLK        (CLK),
		.RESET_X    (RESET_X),
		.keyEvent   (keyEvent),
		.eventValid (eventValid),
		.lastEvent  (lastEvent),
		.lastValid  (lastValid),
		.heldCount  (heldCount),
		.mods       (mods)
	);

endmodule

`default_nettype wire

//--- ps2HostModel.sv
`timescale 1ns/100ps
`default_nettype none

module ps2HostModel
(
	input  wire logic CLK,
	output logic      ps2Clk,
	output logic      ps2Data
);

	localparam int HALF_BIT = 10;	// system cycles per ps2 clock phase.

	initial
	begin
		ps2Clk  = 1'b1;
		ps2Data = 1'b1;
	end

	task automatic waitCycles(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	// start, data lsb first, odd parity, stop.
	task automatic driveFrame(input logic [7:0] value, input logic flipParity, input int bits);
		logic [10:0] frame;
		int i;
		frame = {1'b1, ~(^value) ^ flipParity, value, 1'b0};
		for (i = 0; i < bits; i++)
		begin
			ps2Data = frame[i];	// set while the clock is high.
			waitCycles(HALF_BIT);
			ps2Clk = 1'b0;
			waitCycles(HALF_BIT);
			ps2Clk = 1'b1;
		end
		ps2Data = 1'b1;	// a short frame just stops here.
		waitCycles(HALF_BIT);
	endtask

	task automatic sendByte(input logic [7:0] value);
		driveFrame(value, 1'b0, 11);
	endtask

	task automatic sendBadParity(input logic [7:0] value);
		driveFrame(value, 1'b1, 11);
	endtask

	// clock stops after the start bit and three data bits.
	task automatic sendTruncated(input logic [7:0] value);
		driveFrame(value, 1'b0, 4);
	endtask

endmodule

`default_nettype wire

//--- ps2KeyboardTb.sv
`timescale 1ns/100ps
`default_nettype none

module ps2KeyboardTb;

	localparam int FRAME_COUNT = 22;	// full and truncated frames sent.
	localparam int STALL_COUNT = 1;
	localparam int CYCLE_LIMIT = 2 * (FRAME_COUNT * 11 * 20 +
		STALL_COUNT * int'(ps2Pkg::FRAME_TIMEOUT));

	logic CLK;
	logic RESET_X;
	logic ps2Clk;
	logic ps2Data;
	ps2Pkg::keyEvent_t lastEvent;
	logic lastValid;
	logic [ps2Pkg::HELD_COUNT_W-1:0] heldCount;
	ps2Pkg::modifiers_t mods;
	logic frameError;

	ps2Pkg::keyEvent_t expQ[$];
	ps2Pkg::keyEvent_t expHead = '0;
	logic expPending = 1'b0;
	logic [ps2Pkg::HELD_MAP_SIZE-1:0] expMap = '0;
	logic [ps2Pkg::HELD_COUNT_W-1:0] expCount = '0;
	ps2Pkg::modifiers_t expMods = '0;
	logic errArmed = 1'b0;
	int eventsSeen = 0;
	int errSeen = 0;
	int evExpected = 0;
	int errSent = 0;
	int mismatches = 0;
	int failures = 0;
	int cycleCount = 0;

	ps2Keyboard dut (
		.CLK        (CLK),
		.RESET_X    (RESET_X),
		.ps2Clk     (ps2Clk),
		.ps2Data    (ps2Data),
		.lastEvent  (lastEvent),
		.lastValid  (lastValid),
		.heldCount  (heldCount),
		.mods       (mods),
		.frameError (frameError)
	);

	ps2HostModel host (
		.CLK     (CLK),
		.ps2Clk  (ps2Clk),
		.ps2Data (ps2Data)
	);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	// head of the queue is what the next lastValid must show.
	always @(posedge CLK)
	begin
		if (lastValid)
		begin
			eventsSeen <= eventsSeen + 1;
			if (expQ.size() > 0)
				void'(expQ.pop_front());
		end
		if (frameError)
			errSeen <= errSeen + 1;
		expPending <= (expQ.size() != 0);
		if (expQ.size() != 0)
			expHead <= expQ[0];
	end

	eventMatch: assert property (@(posedge CLK) disable iff (!RESET_X)
		lastValid |-> expPending && (lastEvent == expHead))
		else
		begin
			mismatches++;
			$display("mismatch %0t: event %h, expected %h", $time, $sampled(lastEvent), expHead);
		end

	stateMatch: assert property (@(posedge CLK) disable iff (!RESET_X)
		lastValid |-> (heldCount == expCount) && (mods == expMods))
		else
		begin
			mismatches++;
			$display("mismatch %0t: held %0d mods %b, expected %0d %b", $time,
				$sampled(heldCount), $sampled(mods), expCount, expMods);
		end

	stateHold: assert property (@(posedge CLK) disable iff (!RESET_X)
		!lastValid |-> $stable(heldCount) && $stable(mods))
		else
		begin
			mismatches++;
			$display("mismatch %0t: key state moved without an event", $time);
		end

	errorOnlyWhenSent: assert property (@(posedge CLK) disable iff (!RESET_X)
		frameError |-> errArmed)
		else
		begin
			failures++;
			$display("frame error at %0t without a bad frame sent", $time);
		end

	function automatic logic [7:0] drawCode(input logic [7:0] avoid);
		logic [7:0] c;
		c = 8'($urandom());
		while (c == ps2Pkg::EXT_PREFIX || c == ps2Pkg::BREAK_PREFIX || c == avoid ||
			c == ps2Pkg::LSHIFT_CODE || c == ps2Pkg::RSHIFT_CODE ||
			c == ps2Pkg::CTRL_CODE || c == ps2Pkg::ALT_CODE)
			c = 8'($urandom());
		return c;
	endfunction

	// mirror of the held map.
	task automatic expectEvent(input logic [7:0] code, input logic pressed, input logic ext);
		ps2Pkg::keyEvent_t ev;
		ev.code     = code;
		ev.pressed  = pressed;
		ev.extended = ext;
		if (pressed && !expMap[{ext, code}])
		begin
			expMap[{ext, code}] = 1'b1;
			expCount = expCount + 1'b1;
		end
		else if (!pressed && expMap[{ext, code}])
		begin
			expMap[{ext, code}] = 1'b0;
			expCount = expCount - 1'b1;
		end
		expMods.shift = expMap[{1'b0, ps2Pkg::LSHIFT_CODE}] | expMap[{1'b0, ps2Pkg::RSHIFT_CODE}];
		expMods.ctrl  = expMap[{1'b0, ps2Pkg::CTRL_CODE}] | expMap[{1'b1, ps2Pkg::CTRL_CODE}];
		expMods.alt   = expMap[{1'b0, ps2Pkg::ALT_CODE}] | expMap[{1'b1, ps2Pkg::ALT_CODE}];
		evExpected++;
		expQ.push_back(ev);
	endtask

	task automatic waitSeen(input int limit, input string what);
		int i;
		i = 0;
		while (i < limit && (eventsSeen < evExpected || errSeen < errSent))
		begin
			@(posedge CLK);
			i++;
		end
		if (eventsSeen < evExpected || errSeen < errSent)
		begin
			failures++;
			$display("%s at %0t", what, $time);
		end
		@(posedge CLK);
		#1;
	endtask

	task automatic keyStroke(input logic [7:0] code, input logic pressed, input logic ext);
		if (ext)
			host.sendByte(ps2Pkg::EXT_PREFIX);
		if (!pressed)
			host.sendByte(ps2Pkg::BREAK_PREFIX);
		expectEvent(code, pressed, ext);
		host.sendByte(code);
		waitSeen(100, "key event did not arrive");
	endtask

	initial
	begin
		logic [7:0] firstKey;
		logic [7:0] otherKey;
		void'($urandom(34871));
		RESET_X = 1'b0;
		repeat (5) @(posedge CLK);
		#1 RESET_X = 1'b1;
		repeat (3) @(posedge CLK);
		#1;
		firstKey = drawCode(ps2Pkg::EXT_PREFIX);
		keyStroke(firstKey, 1'b1, 1'b0);
		keyStroke(8'h70, 1'b1, 1'b1);	// extended insert.
		keyStroke(8'h70, 1'b0, 1'b1);
		keyStroke(firstKey, 1'b1, 1'b0);	// typematic repeats.
		keyStroke(firstKey, 1'b1, 1'b0);
		otherKey = drawCode(firstKey);
		keyStroke(otherKey, 1'b0, 1'b0);	// break of a key not held.
		keyStroke(ps2Pkg::LSHIFT_CODE, 1'b1, 1'b0);
		keyStroke(ps2Pkg::CTRL_CODE, 1'b1, 1'b1);
		keyStroke(ps2Pkg::ALT_CODE, 1'b1, 1'b0);
		keyStroke(ps2Pkg::RSHIFT_CODE, 1'b1, 1'b0);
		keyStroke(ps2Pkg::LSHIFT_CODE, 1'b0, 1'b0);
		otherKey = drawCode(firstKey);
		host.sendByte(ps2Pkg::EXT_PREFIX);
		errArmed = 1'b1;
		errSent++;
		host.sendBadParity(otherKey);
		waitSeen(100, "no frame error after a bad parity bit");
		errArmed = 1'b0;
		keyStroke(otherKey, 1'b1, 1'b0);	// prefix must be gone.
		otherKey = drawCode(firstKey);
		errArmed = 1'b1;
		errSent++;
		host.sendTruncated(otherKey);
		waitSeen(int'(ps2Pkg::FRAME_TIMEOUT) + 100, "watchdog did not abort a stalled frame");
		errArmed = 1'b0;
		keyStroke(otherKey, 1'b1, 1'b0);
		if (expQ.size() != 0)
		begin
			failures++;
			$display("%0d expected events never arrived", expQ.size());
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- ps2Keyboard.f
ps2Pkg.sv
ps2FrameRx.sv
ps2ScanDecode.sv
ps2KeyState.sv
ps2Keyboard.sv
ps2HostModel.sv
ps2KeyboardTb.sv

//--- Makefile
TOP = ps2KeyboardTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		--top-module $(TOP) -f ps2Keyboard.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "sim passed"

clean:
	rm -rf obj_dir
